// ==== filelist.f ====
hex_lcd_pkg.sv
pixel_scanner.sv
hex_glyph_lane.sv
lcd_spi_streamer.sv
hex_lcd_top.sv
hex_lcd_properties.sv
hex_lcd_tb.sv

// ==== hex_glyph_lane.sv ====
`timescale 1ns/1ps

module hex_glyph_lane #(
    parameter int COLOR_BITS = 16,
    parameter int LANE_INDEX = 0
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               grp_valid,
    input  logic [7:0]                         grp_x,
    input  logic [7:0]                         grp_y,
    input  logic                               grp_first,
    input  logic                               grp_last,
    input  logic [hex_lcd_pkg::DATA_BITS-1:0]  frame_data,
    input  logic                               px_ready,
    output logic                               in_ready,
    output logic                               px_valid,
    output logic [COLOR_BITS-1:0]              px_color,
    output logic                               px_first,
    output logic                               px_last
);

    logic                  armed;
    logic [7:0]            px_x;
    logic [7:0]            cell_col;
    logic [7:0]            cell_row;
    logic [2:0]            gx;
    logic [2:0]            gy;
    logic [3:0]            nibble;
    logic [4:0]            glyph_bits;
    logic                  pixel_on;
    logic [COLOR_BITS-1:0] color;

    // coordinate split and font lookup
    always_comb
    begin
        int digit;
        int nib_lsb;
        px_x     = grp_x + 8'(LANE_INDEX);
        cell_col = px_x / 8'(hex_lcd_pkg::GLYPH_W);
        gx       = 3'(px_x % 8'(hex_lcd_pkg::GLYPH_W));
        cell_row = grp_y / 8'(hex_lcd_pkg::GLYPH_H);
        gy       = 3'(grp_y % 8'(hex_lcd_pkg::GLYPH_H));

        // msb nibble sits at the top left
        digit   = int'(cell_row) * hex_lcd_pkg::DIGITS_PER_ROW + int'(cell_col);
        nib_lsb = hex_lcd_pkg::DATA_BITS - 4 - 4 * digit;
        nibble  = frame_data[nib_lsb +: 4];

        glyph_bits = hex_lcd_pkg::glyph_row(nibble, gy);
        pixel_on   = 1'b0;
        if (gx < 3'd5)
            pixel_on = glyph_bits[3'd4 - gx]; // bit 4 is the leftmost pixel

        color = pixel_on ? COLOR_BITS'(hex_lcd_pkg::FG_COLOR)
                         : COLOR_BITS'(hex_lcd_pkg::BG_COLOR);
    end

    // one-entry output stage that refills in the cycle it drains
    assign in_ready = armed && (!px_valid || px_ready);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            armed    <= 1'b0;
            px_valid <= 1'b0;
        end
        else
        begin
            armed <= 1'b1;
            if (in_ready)
                px_valid <= grp_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (grp_valid && in_ready)
        begin
            px_color <= color;
            px_first <= grp_first;
            px_last  <= grp_last;
        end
    end

endmodule

// ==== hex_lcd_pkg.sv ====
package hex_lcd_pkg;

    localparam int DATA_BITS      = 128;
    localparam int DIGITS_PER_ROW = 8;
    localparam int GLYPH_W        = 6;   // 5 pixel glyph + 1 spacer column
    localparam int GLYPH_H        = 8;
    localparam int SCREEN_W       = 48;
    localparam int SCREEN_H       = 32;

    localparam logic [7:0] CMD_RAMWR = 8'h2C;

    // rgb565
    localparam logic [15:0] FG_COLOR = 16'hFFFF;
    localparam logic [15:0] BG_COLOR = 16'h001F;

    // 5x7 hex font with row 0 in the top bits and row 7 left blank
    function automatic logic [4:0] glyph_row(input logic [3:0] nibble, input logic [2:0] row);
        logic [34:0] g;
        case (nibble)
            4'h0:    g = 35'b01110_10001_10011_10101_11001_10001_01110;
            4'h1:    g = 35'b00100_01100_00100_00100_00100_00100_01110;
            4'h2:    g = 35'b01110_10001_00001_00010_00100_01000_11111;
            4'h3:    g = 35'b11111_00010_00100_00010_00001_10001_01110;
            4'h4:    g = 35'b00010_00110_01010_10010_11111_00010_00010;
            4'h5:    g = 35'b11111_10000_11110_00001_00001_10001_01110;
            4'h6:    g = 35'b00110_01000_10000_11110_10001_10001_01110;
            4'h7:    g = 35'b11111_00001_00010_00100_01000_01000_01000;
            4'h8:    g = 35'b01110_10001_10001_01110_10001_10001_01110;
            4'h9:    g = 35'b01110_10001_10001_01111_00001_00010_01100;
            4'hA:    g = 35'b01110_10001_10001_10001_11111_10001_10001;
            4'hB:    g = 35'b11110_10001_10001_11110_10001_10001_11110;
            4'hC:    g = 35'b01110_10001_10000_10000_10000_10001_01110;
            4'hD:    g = 35'b11100_10010_10001_10001_10001_10010_11100;
            4'hE:    g = 35'b11111_10000_10000_11110_10000_10000_11111;
            default: g = 35'b11111_10000_10000_11110_10000_10000_10000; // F
        endcase
        if (row == 3'd7)
            return 5'b00000; // descender row stays empty
        return g[34 - 5 * row -: 5];
    endfunction

endpackage

// ==== hex_lcd_properties.sv ====
`timescale 1ns/1ps

module hex_lcd_properties #(
    parameter int LANES = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [LANES-1:0]                   lane_in_ready,
    input  logic                               grp_valid,
    input  logic [7:0]                         grp_x,
    input  logic [7:0]                         grp_y,
    input  logic                               grp_first,
    input  logic                               grp_last,
    input  logic [hex_lcd_pkg::DATA_BITS-1:0]  frame_data,
    input  logic                               lcd_csn,
    input  logic                               lcd_sclk,
    input  logic                               lcd_mosi,
    input  logic                               lcd_dc
);

    // scanner only looks at lane 0, so every lane has to agree
    lanes_in_step: assert property (@(posedge clk) disable iff (!rst_n)
        (&lane_in_ready) || (lane_in_ready == '0))
        else $error("lane in_ready values differ");

    grp_held: assert property (@(posedge clk) disable iff (!rst_n)
        grp_valid && !lane_in_ready[0] |=> grp_valid && $stable(grp_x) && $stable(grp_y)
            && $stable(grp_first) && $stable(grp_last) && $stable(frame_data))
        else $error("group payload changed while stalled");

    sclk_parked: assert property (@(posedge clk) disable iff (!rst_n)
        lcd_csn |-> !lcd_sclk)
        else $error("sclk high while csn is high");

    // panel samples on the rising edge
    dc_steady: assert property (@(posedge clk) disable iff (!rst_n)
        lcd_sclk |-> $stable(lcd_dc) && $stable(lcd_mosi))
        else $error("dc or mosi moved while sclk was high");

endmodule

bind hex_lcd_top hex_lcd_properties #(
    .LANES(LANES)
) hex_lcd_properties_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .lane_in_ready(lane_in_ready),
    .grp_valid    (grp_valid),
    .grp_x        (grp_x),
    .grp_y        (grp_y),
    .grp_first    (grp_first),
    .grp_last     (grp_last),
    .frame_data   (frame_data),
    .lcd_csn      (lcd_csn),
    .lcd_sclk     (lcd_sclk),
    .lcd_mosi     (lcd_mosi),
    .lcd_dc       (lcd_dc)
);

// ==== hex_lcd_tb.sv ====
`timescale 1ns/1ps

module hex_lcd_tb;

    localparam int COLOR_BITS     = 16;
    localparam int LANES          = 4;
    localparam int DATA_BITS      = hex_lcd_pkg::DATA_BITS;
    localparam int NUM_FRAMES     = 3;
    localparam int PIXELS         = hex_lcd_pkg::SCREEN_W * hex_lcd_pkg::SCREEN_H;
    localparam int GROUP_CYCLES   = LANES * COLOR_BITS * 2;
    localparam int FRAME_CYCLES   = 16 + (PIXELS / LANES) * GROUP_CYCLES + 4;
    localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 1000;

    localparam int ITEM_CMD   = 0;
    localparam int ITEM_PIXEL = 1;
    localparam int ITEM_END   = 2;   // csn went back high

    localparam logic [DATA_BITS-1:0] COUNT_PATTERN = 128'h0123456789ABCDEF0123456789ABCDEF;

    logic                 clk;
    logic                 rst_n;
    logic [DATA_BITS-1:0] data;
    logic                 lcd_csn;
    logic                 lcd_sclk;
    logic                 lcd_mosi;
    logic                 lcd_dc;

    integer               seed = 32'hdaf8a1db;
    int                   cycle_cnt = 0;
    logic [DATA_BITS-1:0] frame_word [NUM_FRAMES];

    // receiver state
    int                    item_kind [$];
    logic [COLOR_BITS-1:0] item_val [$];
    logic                  sclk_q = 1'b0;
    logic                  csn_q = 1'b1;
    logic                  rx_dc = 1'b0;
    logic [COLOR_BITS-1:0] rx_shift = '0;
    int                    rx_bits = 0;
    int                    csn_high_cycles = 0;
    bit                    reset_checked = 1'b0;

    // progress of the comparing process
    int                    cur_frame = 0;
    int                    cur_pix = 0;

    hex_lcd_top #(
        .COLOR_BITS(COLOR_BITS),
        .LANES     (LANES)
    ) hex_lcd_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .data    (data),
        .lcd_csn (lcd_csn),
        .lcd_sclk(lcd_sclk),
        .lcd_mosi(lcd_mosi),
        .lcd_dc  (lcd_dc)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_cmd(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("ERR %s got %h exp %h", name, got, exp);
            abort_run("command byte mismatch");
        end
    endtask

    task automatic check_color(input string name, input logic [COLOR_BITS-1:0] got,
                               input logic [COLOR_BITS-1:0] exp);
        if (got !== exp)
        begin
            $display("ERR %s got %h exp %h", name, got, exp);
            abort_run("pixel colour mismatch");
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("ERR %s got %h exp %h", name, got, exp);
            abort_run("count mismatch");
        end
    endtask

    // colour of one screen pixel for a given data word
    function automatic logic [COLOR_BITS-1:0] expected_color(input logic [DATA_BITS-1:0] word,
                                                             input int x, input int y);
        int         col;
        int         gx;
        int         row;
        int         gy;
        int         digit;
        logic [3:0] nib;
        logic [4:0] pattern;
        col   = x / hex_lcd_pkg::GLYPH_W;
        gx    = x % hex_lcd_pkg::GLYPH_W;
        row   = y / hex_lcd_pkg::GLYPH_H;
        gy    = y % hex_lcd_pkg::GLYPH_H;
        digit = row * hex_lcd_pkg::DIGITS_PER_ROW + col;
        nib   = word[DATA_BITS - 1 - 4 * digit -: 4];   // top left digit is the msb nibble
        pattern = hex_lcd_pkg::glyph_row(nib, 3'(gy));
        if (gx < 5)
        begin
            if (pattern[4 - gx])
                return COLOR_BITS'(hex_lcd_pkg::FG_COLOR);
        end
        return COLOR_BITS'(hex_lcd_pkg::BG_COLOR);   // spacer column lands here too
    endfunction

    // reset, then a new random word halfway through each frame
    initial
    begin
        logic [DATA_BITS-1:0] word;
        rst_n = 1'b0;
        data  = COUNT_PATTERN;
        frame_word[0] = COUNT_PATTERN;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int f = 0; f < NUM_FRAMES - 1; f++)
        begin
            wait (cur_frame == f && cur_pix >= PIXELS / 2);
            @(posedge clk);
            word = {$random(seed), $random(seed), $random(seed), $random(seed)};
            frame_word[f + 1] = word;   // latched at the next frame start
            data <= word;
        end
    end

    // spi receiver looks at the lines just before each clk edge updates them
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (!reset_checked)
            begin
                if (lcd_csn !== 1'b1 || lcd_sclk !== 1'b0)
                    abort_run("csn not high or sclk not low after reset");
                reset_checked = 1'b1;
            end
            if (lcd_csn === 1'b1)
            begin
                csn_high_cycles++;
                if (lcd_sclk !== 1'b0)
                    abort_run("sclk high while csn is high");
                if (!csn_q)
                begin
                    if (rx_bits != 0)
                        abort_run("csn rose in the middle of a word");
                    item_kind.push_back(ITEM_END);
                    item_val.push_back('0);
                end
            end
            else
            begin
                if (csn_q)
                begin
                    if (csn_high_cycles < 2)
                        abort_run("csn gap shorter than one sclk period");
                    csn_high_cycles = 0;
                end
                if (lcd_sclk && !sclk_q)
                begin
                    if (rx_bits == 0)
                        rx_dc = lcd_dc;
                    else if (lcd_dc !== rx_dc)
                        abort_run("dc changed inside a word");
                    rx_shift = {rx_shift[COLOR_BITS-2:0], lcd_mosi};
                    rx_bits++;
                    if (!rx_dc && rx_bits == 8)
                    begin
                        item_kind.push_back(ITEM_CMD);
                        item_val.push_back(rx_shift);
                        rx_bits = 0;
                    end
                    else if (rx_dc && rx_bits == COLOR_BITS)
                    begin
                        item_kind.push_back(ITEM_PIXEL);
                        item_val.push_back(rx_shift);
                        rx_bits = 0;
                    end
                end
            end
            sclk_q = lcd_sclk;
            csn_q  = lcd_csn;
        end
    end

    // compares received items on the falling edge
    initial
    begin
        int                    kind;
        logic [COLOR_BITS-1:0] val;
        logic [COLOR_BITS-1:0] exp_color;
        int                    x;
        int                    y;
        int                    cmd_cnt;
        int                    fg_cnt;
        int                    bg_cnt;
        cmd_cnt = 0;
        fg_cnt  = 0;
        bg_cnt  = 0;
        while (cur_frame < NUM_FRAMES)
        begin
            @(negedge clk);
            while (item_kind.size() > 0 && cur_frame < NUM_FRAMES)
            begin
                kind = item_kind.pop_front();
                val  = item_val.pop_front();
                if (kind == ITEM_CMD)
                begin
                    check_count("lcd_dc low bytes before this one", cmd_cnt, 0);
                    check_cmd("lcd_mosi command", val[7:0], hex_lcd_pkg::CMD_RAMWR);
                    cmd_cnt++;
                end
                else if (kind == ITEM_PIXEL)
                begin
                    if (cmd_cnt == 0)
                        abort_run("pixel data arrived before the command byte");
                    if (cur_pix >= PIXELS)
                        abort_run("more pixels in a frame than the screen holds");
                    x = cur_pix % hex_lcd_pkg::SCREEN_W;
                    y = cur_pix / hex_lcd_pkg::SCREEN_W;
                    exp_color = expected_color(frame_word[cur_frame], x, y);
                    check_color($sformatf("lcd_mosi pixel x=%0d y=%0d frame=%0d", x, y, cur_frame),
                                val, exp_color);
                    if (val == COLOR_BITS'(hex_lcd_pkg::FG_COLOR))
                        fg_cnt++;
                    else
                        bg_cnt++;
                    cur_pix++;
                end
                else
                begin
                    check_count("pixels per frame", cur_pix, PIXELS);
                    check_count("command bytes per frame", cmd_cnt, 1);
                    if (fg_cnt == 0)
                        abort_run("frame has no foreground pixel");
                    if (bg_cnt == 0)
                        abort_run("frame has no background pixel");
                    cur_frame++;
                    cur_pix = 0;
                    cmd_cnt = 0;
                    fg_cnt  = 0;
                    bg_cnt  = 0;
                end
            end
        end
        $display("Simulation completed successfully");
        $finish;
    end

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            abort_run("timeout: frames not completed");
    end

endmodule

// ==== hex_lcd_top.sv ====
`timescale 1ns/1ps

module hex_lcd_top #(
    parameter int COLOR_BITS = 16,
    parameter int LANES      = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [hex_lcd_pkg::DATA_BITS-1:0]  data,
    output logic                               lcd_csn,
    output logic                               lcd_sclk,
    output logic                               lcd_mosi,
    output logic                               lcd_dc
);

    logic                              grp_valid;
    logic [7:0]                        grp_x;
    logic [7:0]                        grp_y;
    logic                              grp_first;
    logic                              grp_last;
    logic [hex_lcd_pkg::DATA_BITS-1:0] frame_data;

    logic [LANES-1:0]                  lane_in_ready;
    logic [LANES-1:0]                  px_valid;
    logic [LANES*COLOR_BITS-1:0]       px_color;
    logic [LANES-1:0]                  lane_first;
    logic [LANES-1:0]                  lane_last;
    logic                              px_ready;

    pixel_scanner #(
        .LANES(LANES)
    ) pixel_scanner_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .data      (data),
        .grp_ready (lane_in_ready[0]), // lanes run in lockstep
        .grp_valid (grp_valid),
        .grp_x     (grp_x),
        .grp_y     (grp_y),
        .grp_first (grp_first),
        .grp_last  (grp_last),
        .frame_data(frame_data)
    );

    for (genvar i = 0; i < LANES; i++)
    begin : g_lane
        hex_glyph_lane #(
            .COLOR_BITS(COLOR_BITS),
            .LANE_INDEX(i)
        ) hex_glyph_lane_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .grp_valid (grp_valid),
            .grp_x     (grp_x),
            .grp_y     (grp_y),
            .grp_first (grp_first),
            .grp_last  (grp_last),
            .frame_data(frame_data),
            .px_ready  (px_ready),
            .in_ready  (lane_in_ready[i]),
            .px_valid  (px_valid[i]),
            .px_color  (px_color[i*COLOR_BITS +: COLOR_BITS]),
            .px_first  (lane_first[i]),
            .px_last   (lane_last[i])
        );
    end

    lcd_spi_streamer #(
        .COLOR_BITS(COLOR_BITS),
        .LANES     (LANES)
    ) lcd_spi_streamer_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .px_valid (px_valid),
        .px_color (px_color),
        .px_first (&lane_first),
        .px_last  (&lane_last),
        .px_ready (px_ready),
        .lcd_csn  (lcd_csn),
        .lcd_sclk (lcd_sclk),
        .lcd_mosi (lcd_mosi),
        .lcd_dc   (lcd_dc)
    );

endmodule

// ==== lcd_spi_streamer.sv ====
`timescale 1ns/1ps

module lcd_spi_streamer #(
    parameter int COLOR_BITS = 16,
    parameter int LANES      = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [LANES-1:0]              px_valid,
    input  logic [LANES*COLOR_BITS-1:0]   px_color,
    input  logic                          px_first,
    input  logic                          px_last,
    output logic                          px_ready,
    output logic                          lcd_csn,
    output logic                          lcd_sclk,
    output logic                          lcd_mosi,
    output logic                          lcd_dc
);

    localparam int PIX_BITS = LANES * COLOR_BITS;
    localparam int MSB      = PIX_BITS - 1;
    localparam int CNT_W    = $clog2(PIX_BITS > 8 ? PIX_BITS : 8);

    localparam logic [CNT_W-1:0] PIX_LAST = CNT_W'(PIX_BITS - 1);
    localparam logic [CNT_W-1:0] CMD_LAST = CNT_W'(7);
    localparam logic [1:0]       GAP_LAST = 2'd3; // csn high for 4 cycles

    typedef enum logic [1:0] {
        S_IDLE,
        S_CMD,
        S_PIXELS,
        S_GAP
    } state_t;

    state_t             state;
    logic               phase;     // 0 sclk low, 1 sclk high
    logic [CNT_W-1:0]   bit_cnt;
    logic [1:0]         gap_cnt;
    logic               last_flag;
    logic [7:0]         cmd_sr;
    logic [PIX_BITS-1:0] pix_sr;
    logic [PIX_BITS-1:0] group_word;
    logic               accept;

    // lane 0 ends up in the top bits, so it leaves first
    always_comb
    begin
        for (int i = 0; i < LANES; i++)
            group_word[(LANES - 1 - i) * COLOR_BITS +: COLOR_BITS] =
                px_color[i * COLOR_BITS +: COLOR_BITS];
    end

    // ready in idle, and on the very last cycle of a group or gap so frames run back to back
    assign px_ready = (state == S_IDLE)
                   || (state == S_PIXELS && phase && bit_cnt == PIX_LAST && !last_flag)
                   || (state == S_GAP && gap_cnt == GAP_LAST);
    assign accept = px_ready && (&px_valid);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state     <= S_GAP; // csn idles high for one gap before the first frame
            phase     <= 1'b0;
            bit_cnt   <= '0;
            gap_cnt   <= 2'd0;
            last_flag <= 1'b0;
            lcd_csn   <= 1'b1;
            lcd_sclk  <= 1'b0;
            lcd_mosi  <= 1'b0;
            lcd_dc    <= 1'b0;
        end
        else if (accept)
        begin
            phase     <= 1'b0;
            bit_cnt   <= '0;
            last_flag <= px_last;
            lcd_csn   <= 1'b0;
            lcd_sclk  <= 1'b0;
            if (px_first)
            begin
                state    <= S_CMD; // ramwr ahead of the frame
                lcd_mosi <= hex_lcd_pkg::CMD_RAMWR[7];
                lcd_dc   <= 1'b0;
            end
            else
            begin
                state    <= S_PIXELS;
                lcd_mosi <= group_word[MSB];
                lcd_dc   <= 1'b1;
            end
        end
        else
        begin
            case (state)
                S_CMD, S_PIXELS:
                begin
                    phase    <= !phase;
                    lcd_sclk <= !phase;
                    if (phase)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (state == S_CMD && bit_cnt == CMD_LAST)
                        begin
                            state    <= S_PIXELS;
                            bit_cnt  <= '0;
                            lcd_mosi <= pix_sr[MSB];
                            lcd_dc   <= 1'b1;
                        end
                        else if (state == S_PIXELS && bit_cnt == PIX_LAST)
                        begin
                            if (last_flag)
                            begin
                                state    <= S_GAP; // end of frame
                                gap_cnt  <= 2'd0;
                                lcd_csn  <= 1'b1;
                                lcd_mosi <= 1'b0;
                                lcd_dc   <= 1'b0;
                            end
                            else
                            begin
                                state <= S_IDLE; // lanes ran dry, hold the line
                            end
                        end
                        else
                        begin
                            lcd_mosi <= (state == S_CMD) ? cmd_sr[7] : pix_sr[MSB];
                        end
                    end
                end
                S_GAP:
                begin
                    if (gap_cnt == GAP_LAST)
                        state <= S_IDLE;
                    else
                        gap_cnt <= gap_cnt + 2'd1;
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // shift registers hold the bits still to send
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cmd_sr <= {hex_lcd_pkg::CMD_RAMWR[6:0], 1'b0};
            pix_sr <= px_first ? group_word : group_word << 1;
        end
        else if (phase)
        begin
            if (state == S_CMD)
                cmd_sr <= cmd_sr << 1;
            if (state == S_PIXELS || (state == S_CMD && bit_cnt == CMD_LAST))
                pix_sr <= pix_sr << 1;
        end
    end

endmodule

// ==== pixel_scanner.sv ====
`timescale 1ns/1ps

module pixel_scanner #(
    parameter int LANES = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [hex_lcd_pkg::DATA_BITS-1:0]  data,
    input  logic                               grp_ready,
    output logic                               grp_valid,
    output logic [7:0]                         grp_x,
    output logic [7:0]                         grp_y,
    output logic                               grp_first,
    output logic                               grp_last,
    output logic [hex_lcd_pkg::DATA_BITS-1:0]  frame_data
);

    localparam logic [7:0] X_STEP = 8'(LANES);
    localparam logic [7:0] X_LAST = 8'(hex_lcd_pkg::SCREEN_W - LANES);
    localparam logic [7:0] Y_LAST = 8'(hex_lcd_pkg::SCREEN_H - 1);

    logic grp_xfer;
    logic load_frame;

    assign grp_xfer = grp_valid && grp_ready;

    // counters at 0,0 mean the first group of a new frame is being loaded
    assign load_frame = !grp_valid || (grp_xfer && grp_last);

    assign grp_first = (grp_x == 8'd0) && (grp_y == 8'd0);
    assign grp_last  = (grp_x == X_LAST) && (grp_y == Y_LAST);

    // raster walk with x stepping by LANES before y moves on
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            grp_valid <= 1'b0;
            grp_x     <= 8'd0;
            grp_y     <= 8'd0;
        end
        else
        begin
            grp_valid <= 1'b1; // a group is always available
            if (grp_xfer)
            begin
                if (grp_x == X_LAST)
                begin
                    grp_x <= 8'd0;
                    if (grp_y == Y_LAST)
                        grp_y <= 8'd0; // wrap to next frame
                    else
                        grp_y <= grp_y + 8'd1;
                end
                else
                begin
                    grp_x <= grp_x + X_STEP;
                end
            end
        end
    end

    // word is frozen for the whole frame so the picture never tears
    always_ff @(posedge clk)
    begin
        if (load_frame)
            frame_data <= data;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with verilator and runs it, the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module hex_lcd_tb \
    -f filelist.f -o hex_lcd_sim &&
./obj_dir/hex_lcd_sim ||
exit 1
